// File: Makefile
# Verilator build and run of the PID controller testbench

VERILATOR ?= verilator
TOP       ?= pid_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

PASS_MSG  := *** TEST PASSED ***
SRCS      := $(shell grep -v '^+' $(FILELIST))
HDRS      := $(wildcard bench/*.svh)
BIN       := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -qF '$(PASS_MSG)' $(LOG); then \
		echo "Simulation passed, log in $(LOG)"; \
	else \
		echo "Simulation failed, log in $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/pid_tb_vectors.svh
`ifndef PID_TB_VECTORS_SVH
`define PID_TB_VECTORS_SVH

// Columns: kind, channel, register address, value
// Sample rows carry the input data in value, or rnd_data in the address column
typedef enum logic [1:0] {
    k_idle,
    k_write,
    k_sample,
    k_clear
} row_kind_e;

typedef struct packed {
    row_kind_e              kind;
    logic [pid_w_chan-1:0]  chan;
    logic [2:0]             addr;
    logic [31:0]            value;
} vec_row_t;

// Sample data drawn from $urandom
localparam logic [2:0] rnd_data = 3'd1;

localparam int n_rows = 84;

localparam vec_row_t vec_table [n_rows] = '{
    // Reset gains, round robin over all channels
    '{k_sample, 4'd0, rnd_data, 32'd0},  '{k_sample, 4'd1, rnd_data, 32'd0},
    '{k_sample, 4'd2, rnd_data, 32'd0},  '{k_sample, 4'd3, rnd_data, 32'd0},
    '{k_sample, 4'd4, rnd_data, 32'd0},  '{k_sample, 4'd5, rnd_data, 32'd0},
    '{k_sample, 4'd6, rnd_data, 32'd0},  '{k_sample, 4'd7, rnd_data, 32'd0},
    '{k_sample, 4'd0, rnd_data, 32'd0},  '{k_sample, 4'd1, rnd_data, 32'd0},
    '{k_sample, 4'd2, rnd_data, 32'd0},  '{k_sample, 4'd3, rnd_data, 32'd0},
    '{k_sample, 4'd4, rnd_data, 32'd0},  '{k_sample, 4'd5, rnd_data, 32'd0},
    '{k_sample, 4'd6, rnd_data, 32'd0},  '{k_sample, 4'd7, rnd_data, 32'd0},
    // Full PID settings on channels 0 to 2
    '{k_write, 4'd0, addr_setpoint, 32'd1000},  '{k_write, 4'd0, addr_p_coef, 32'd3},
    '{k_write, 4'd0, addr_i_coef, 32'd1},       '{k_write, 4'd0, addr_d_coef, 32'd2},
    '{k_write, 4'd1, addr_setpoint, -32'sd500}, '{k_write, 4'd1, addr_p_coef, 32'd5},
    '{k_write, 4'd1, addr_i_coef, 32'd2},       '{k_write, 4'd1, addr_d_coef, 32'd1},
    '{k_write, 4'd2, addr_setpoint, 32'd2000},  '{k_write, 4'd2, addr_p_coef, 32'd2},
    '{k_write, 4'd2, addr_i_coef, 32'd1},       '{k_write, 4'd2, addr_d_coef, 32'd4},
    '{k_sample, 4'd0, 3'd0, 32'd900},   '{k_sample, 4'd1, 3'd0, -32'sd400},
    '{k_sample, 4'd2, 3'd0, 32'd2100},  '{k_sample, 4'd3, 3'd0, 32'd50},
    '{k_sample, 4'd0, 3'd0, 32'd800},   '{k_sample, 4'd1, 3'd0, -32'sd300},
    '{k_sample, 4'd2, 3'd0, 32'd1800},  '{k_sample, 4'd3, 3'd0, -32'sd20},
    '{k_sample, 4'd0, 3'd0, 32'd1200},  '{k_sample, 4'd1, 3'd0, -32'sd700},
    '{k_sample, 4'd2, 3'd0, 32'd2500},  '{k_sample, 4'd3, 3'd0, 32'd10},
    // Inverted error on channel 2 only
    '{k_write, 4'd2, addr_inv_error, 32'd1}, '{k_sample, 4'd0, 3'd0, 32'd1000},
    '{k_sample, 4'd1, 3'd0, -32'sd600},  '{k_sample, 4'd2, 3'd0, 32'd1900},
    '{k_sample, 4'd3, 3'd0, 32'd5},      '{k_sample, 4'd0, 3'd0, 32'd950},
    '{k_sample, 4'd1, 3'd0, -32'sd500},  '{k_sample, 4'd2, 3'd0, 32'd2200},
    // Large gains, channel 4 to the top rail and channel 5 to the bottom
    '{k_sample, 4'd3, 3'd0, -32'sd15},   '{k_write, 4'd4, addr_setpoint, 32'd100000},
    '{k_write, 4'd4, addr_p_coef, 32'd32767},    '{k_write, 4'd4, addr_i_coef, 32'd32767},
    '{k_write, 4'd5, addr_setpoint, -32'sd100000}, '{k_write, 4'd5, addr_p_coef, 32'd32767},
    '{k_write, 4'd5, addr_i_coef, 32'd32767},    '{k_sample, 4'd4, 3'd0, -32'sd100000},
    '{k_sample, 4'd5, 3'd0, 32'd100000}, '{k_sample, 4'd6, rnd_data, 32'd0},
    '{k_sample, 4'd7, rnd_data, 32'd0},  '{k_sample, 4'd4, 3'd0, -32'sd100000},
    '{k_sample, 4'd5, 3'd0, 32'd100000}, '{k_sample, 4'd6, rnd_data, 32'd0},
    // Clear of channel 0 with one sample in flight and the next blocked at entry
    '{k_sample, 4'd7, rnd_data, 32'd0},  '{k_sample, 4'd0, 3'd0, 32'd700},
    '{k_sample, 4'd1, 3'd0, -32'sd550},  '{k_sample, 4'd2, 3'd0, 32'd2100},
    '{k_clear, 4'd0, 3'd0, 32'd1},       '{k_sample, 4'd0, 3'd0, 32'd1500},
    '{k_sample, 4'd3, 3'd0, 32'd30},     '{k_sample, 4'd1, 3'd0, -32'sd620},
    '{k_sample, 4'd2, 3'd0, 32'd1800},   '{k_sample, 4'd0, 3'd0, 32'd600},
    '{k_sample, 4'd3, 3'd0, -32'sd40},   '{k_sample, 4'd1, 3'd0, -32'sd640},
    '{k_idle, 4'd0, 3'd0, 32'd0},        '{k_sample, 4'd0, 3'd0, 32'd650},
    // Writes beyond the last channel, then samples on the channels they would alias to
    '{k_write, 4'd8, addr_p_coef, 32'd1000}, '{k_write, 4'd8, addr_setpoint, 32'd50000},
    '{k_write, 4'd15, addr_inv_error, 32'd1}, '{k_sample, 4'd0, 3'd0, 32'd700},
    '{k_sample, 4'd1, 3'd0, -32'sd500},  '{k_sample, 4'd7, 3'd0, 32'd300},
    '{k_idle, 4'd0, 3'd0, 32'd0},        '{k_sample, 4'd0, 3'd0, 32'd720}
};

`endif

// File: bench/pid_tb.sv
`timescale 1ns/1ps

module pid_tb
    import pid_pkg::*;
();

    localparam int n_chan = 8;
    localparam int w_dout = 24;
    localparam int half_period = 20;
    // Cycles allowed for the pipeline to empty at the end
    localparam int drain_limit = 40;

    `include "pid_tb_vectors.svh"

    logic                     clk_in;
    logic                     rst_n;
    logic                     wr_en;
    pid_wr_t                  wr;
    logic                     dv_in;
    pid_sample_t              sample_in;
    logic                     dv_out;
    logic [pid_w_chan-1:0]    chan_out;
    logic signed [w_dout-1:0] data_out;

    // One expected output, stamp is the edge its sample was driven on
    typedef struct {
        int     chan;
        longint value;
        longint stamp;
    } exp_t;

    exp_t   exp_q[$];
    longint edge_cnt;

    // -----------------------------------------------
    // Reference model state
    // -----------------------------------------------
    longint m_setpoint [n_chan];
    longint m_p [n_chan];
    longint m_i [n_chan];
    longint m_d [n_chan];
    bit     m_inv [n_chan];
    longint m_err1 [n_chan];
    longint m_err2 [n_chan];
    longint m_out [n_chan];
    // Last drive edge whose sample a clear still drops
    longint m_block [n_chan];

    pid_top #(
        .N_CHAN (n_chan),
        .W_DOUT (w_dout)
    ) i_pid_top (
        .clk_in    (clk_in),
        .rst_n     (rst_n),
        .wr_en     (wr_en),
        .wr        (wr),
        .dv_in     (dv_in),
        .sample_in (sample_in),
        .dv_out    (dv_out),
        .chan_out  (chan_out),
        .data_out  (data_out)
    );

    always #half_period clk_in = ~clk_in;

    always @(posedge clk_in) begin
        edge_cnt <= edge_cnt + 1;
    end

    task automatic check_value(input string name, input longint actual, input longint expected);
        if (actual !== expected) begin
            $display("Fail %s: got %h, expected %h", name, actual, expected);
            $display("*** TEST FAILED ***");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("*** TEST FAILED ***");
        $fatal(1, "run aborted");
    endtask

    // Clamp to the signed output range
    function automatic longint saturate(input longint v);
        longint hi;
        longint lo;
        hi = (longint'(1) <<< (w_dout - 1)) - 1;
        lo = -(longint'(1) <<< (w_dout - 1));
        if (v > hi) begin
            return hi;
        end else if (v < lo) begin
            return lo;
        end
        return v;
    endfunction

    task automatic init_model();
        for (int c = 0; c < n_chan; c++) begin
            m_setpoint[c] = 0;
            m_p[c] = 1;
            m_i[c] = 0;
            m_d[c] = 0;
            m_inv[c] = 1'b0;
            m_err1[c] = 0;
            m_err2[c] = 0;
            m_out[c] = 0;
            m_block[c] = -1;
        end
    endtask

    // Writes past the last channel are dropped
    task automatic record_write(input int c, input logic [2:0] addr, input logic [31:0] value);
        if (c < n_chan) begin
            case (pid_addr_e'(addr))
                addr_setpoint:  m_setpoint[c] = longint'($signed(value[pid_w_din-1:0]));
                addr_p_coef:    m_p[c] = longint'($signed(value[pid_w_coef-1:0]));
                addr_i_coef:    m_i[c] = longint'($signed(value[pid_w_coef-1:0]));
                addr_d_coef:    m_d[c] = longint'($signed(value[pid_w_coef-1:0]));
                addr_inv_error: m_inv[c] = value[0];
                default: ;
            endcase
        end
    endtask

    // Pulse lands one edge after the write is sampled
    // and kills samples driven from four edges before up to one edge after
    task automatic flush_channel(input int c, input longint stamp);
        exp_t keep_q[$];
        if (c < n_chan) begin
            foreach (exp_q[n]) begin
                if (!(exp_q[n].chan == c && exp_q[n].stamp >= stamp - 4)) begin
                    keep_q.push_back(exp_q[n]);
                end
            end
            exp_q = keep_q;
            m_err1[c] = 0;
            m_err2[c] = 0;
            m_out[c] = 0;
            m_block[c] = stamp + 1;
        end
    endtask

    // Velocity form, k1*e + k2*e[-1] + k3*e[-2] added to the last output
    task automatic predict_output(input int c, input longint din, input longint stamp);
        longint e;
        longint k1;
        longint k2;
        longint k3;
        exp_t   item;
        if (stamp > m_block[c]) begin
            e = m_setpoint[c] - din;
            if (m_inv[c]) begin
                e = -e - 1;
            end
            k1 = m_p[c] + m_i[c] + m_d[c];
            k2 = -m_p[c] - 2 * m_d[c];
            k3 = m_d[c];
            item.value = saturate(m_out[c] + k1 * e + k2 * m_err1[c] + k3 * m_err2[c]);
            item.chan = c;
            item.stamp = stamp;
            m_err2[c] = m_err1[c];
            m_err1[c] = e;
            m_out[c] = item.value;
            exp_q.push_back(item);
        end
    endtask

    // -----------------------------------------------
    // Output monitor, sampled mid-cycle
    // -----------------------------------------------
    always @(negedge clk_in) begin
        exp_t item;
        if (rst_n === 1'b1) begin
            if (dv_out === 1'b1) begin
                if (exp_q.size() == 0) begin
                    abort_run($sformatf("Unexpected dv_out on channel %0d", chan_out));
                end else begin
                    item = exp_q.pop_front();
                    check_value("chan_out", longint'(chan_out), longint'(item.chan));
                    check_value("data_out", longint'(data_out), item.value);
                    // Six edges from drive to strobe
                    check_value("dv_out edge", edge_cnt, item.stamp + 6);
                end
            end else if (exp_q.size() != 0 && edge_cnt > exp_q[0].stamp + 6) begin
                abort_run($sformatf("No dv_out for channel %0d sample driven at edge %0d",
                                    exp_q[0].chan, exp_q[0].stamp));
            end
        end
    end

    initial begin
        logic [31:0]          rnd_word;
        logic [pid_w_din-1:0] din_bits;
        longint               stamp;
        vec_row_t             row;
        pid_wr_t              wr_next;
        int                   wait_cycles;

        clk_in = 1'b0;
        edge_cnt <= 0;
        rst_n <= 1'b0;
        wr_en <= 1'b0;
        wr <= '0;
        dv_in <= 1'b0;
        sample_in <= '0;
        rnd_word = $urandom(32'h28fc9aeb);
        init_model();

        repeat (5) @(posedge clk_in);
        rst_n <= 1'b1;

        // One table row per cycle
        for (int r = 0; r < n_rows; r++) begin
            @(posedge clk_in);
            row = vec_table[r];
            stamp = edge_cnt + 1;
            din_bits = row.value[pid_w_din-1:0];
            if (row.kind == k_sample && row.addr == rnd_data) begin
                rnd_word = $urandom();
                din_bits = rnd_word[pid_w_din-1:0];
            end
            wr_next.addr = (row.kind == k_clear) ? addr_clr_rqst : pid_addr_e'(row.addr);
            wr_next.chan = row.chan;
            wr_next.data = (row.kind == k_clear) ? 32'd1 : row.value;
            wr_en <= (row.kind == k_write) || (row.kind == k_clear);
            wr <= wr_next;
            dv_in <= (row.kind == k_sample);
            sample_in <= '{chan: row.chan, data: din_bits};
            case (row.kind)
                k_write:  record_write(int'(row.chan), row.addr, row.value);
                k_clear:  flush_channel(int'(row.chan), stamp);
                k_sample: predict_output(int'(row.chan), longint'($signed(din_bits)), stamp);
                default: ;
            endcase
        end

        @(posedge clk_in);
        wr_en <= 1'b0;
        dv_in <= 1'b0;

        // Wait for the pipeline to empty
        wait_cycles = 0;
        while (exp_q.size() != 0 && wait_cycles < drain_limit) begin
            @(posedge clk_in);
            wait_cycles++;
        end

        if (exp_q.size() == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            $display("Timed out with %0d outputs still expected", exp_q.size());
            $display("*** TEST FAILED ***");
            $fatal(1, "drain timeout");
        end
    end

endmodule

// File: common/pid_pkg.sv
package pid_pkg;

    // -----------------------------------------------
    // Widths
    // -----------------------------------------------
    // Input sample and setpoint
    localparam int pid_w_din = 18;
    // Each of P, I and D
    localparam int pid_w_coef = 16;
    // Up to 16 channels
    localparam int pid_w_chan = 4;
    // Write bus payload
    localparam int pid_w_wr_data = 32;

    // -----------------------------------------------
    // Register map
    // -----------------------------------------------
    typedef enum logic [2:0] {
        addr_setpoint  = 3'd0,
        addr_p_coef    = 3'd1,
        addr_i_coef    = 3'd2,
        addr_d_coef    = 3'd3,
        addr_inv_error = 3'd4,
        // Data bit 0 requests a channel history clear
        addr_clr_rqst  = 3'd5
    } pid_addr_e;

    // -----------------------------------------------
    // Bundles
    // -----------------------------------------------
    // Tagged input sample
    typedef struct packed {
        logic [pid_w_chan-1:0]       chan;
        logic signed [pid_w_din-1:0] data;
    } pid_sample_t;

    // Settings of one channel
    typedef struct packed {
        logic signed [pid_w_din-1:0]  setpoint;
        logic signed [pid_w_coef-1:0] p_coef;
        logic signed [pid_w_coef-1:0] i_coef;
        logic signed [pid_w_coef-1:0] d_coef;
        logic                         inv_error;
    } pid_coef_t;

    // One register write
    typedef struct packed {
        pid_addr_e                addr;
        logic [pid_w_chan-1:0]    chan;
        logic [pid_w_wr_data-1:0] data;
    } pid_wr_t;

    // Unity proportional gain out of reset
    localparam pid_coef_t pid_coef_reset = '{
        setpoint:  '0,
        p_coef:    16'sd1,
        i_coef:    16'sd0,
        d_coef:    16'sd0,
        inv_error: 1'b0
    };

endpackage

// File: files.f
+incdir+bench
common/pid_pkg.sv
src/pid_param_regs.sv
pid_filter/pid_filter.sv
src/pid_top.sv
bench/pid_tb.sv

// File: pid_filter/pid_filter.sv
`timescale 1ns/1ps

module pid_filter
    import pid_pkg::*;
#(
    parameter int N_CHAN = 8,
    parameter int W_DOUT = 24
) (
    input  logic                     clk_in,
    input  logic                     rst_n,
    // Sample stream
    input  logic                     dv_in,
    input  pid_sample_t              sample_in,
    // Settings and clear pulses from the register block
    input  pid_coef_t [N_CHAN-1:0]   coef,
    input  logic [N_CHAN-1:0]        clr,
    // Controller output
    output logic                     dv_out,
    output logic [pid_w_chan-1:0]    chan_out,
    output logic signed [W_DOUT-1:0] data_out
);

    // -----------------------------------------------
    // Widths and limits
    // -----------------------------------------------
    // One bit more than the sample for the difference
    localparam int w_err = pid_w_din + 1;
    // Headroom for P+I+D and -P-2D
    localparam int w_k = pid_w_coef + 2;
    localparam int w_prod = w_k + w_err;
    // Sum of three products
    localparam int w_delta = w_prod + 2;
    // Previous output plus delta without overflow
    localparam int w_sum = ((W_DOUT > w_delta) ? W_DOUT : w_delta) + 1;
    localparam int w_idx = (N_CHAN > 1) ? $clog2(N_CHAN) : 1;

    localparam logic signed [W_DOUT-1:0] max_dout = {1'b0, {(W_DOUT-1){1'b1}}};
    localparam logic signed [W_DOUT-1:0] min_dout = {1'b1, {(W_DOUT-1){1'b0}}};

    // Memory index from a channel tag
    function automatic logic [w_idx-1:0] idx(input logic [pid_w_chan-1:0] chan);
        return chan[w_idx-1:0];
    endfunction

    // -----------------------------------------------
    // Valid and channel pipeline
    // -----------------------------------------------
    logic [6:1]            dv_p;
    logic [pid_w_chan-1:0] chan_p [1:6];

    // Each stage drops its valid while its channel is cleared
    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            dv_p <= '0;
        end else begin
            dv_p[1] <= dv_in && !clr[idx(sample_in.chan)];
            for (int s = 2; s <= 6; s++) begin
                dv_p[s] <= dv_p[s-1] && !clr[idx(chan_p[s-1])];
            end
        end
    end

    // Channel tag rides along
    always_ff @(posedge clk_in) begin
        chan_p[1] <= sample_in.chan;
        for (int s = 2; s <= 6; s++) begin
            chan_p[s] <= chan_p[s-1];
        end
    end

    // -----------------------------------------------
    // History memories
    // -----------------------------------------------
    logic signed [w_err-1:0]  err_prev1_mem [N_CHAN];
    logic signed [w_err-1:0]  err_prev2_mem [N_CHAN];
    logic signed [W_DOUT-1:0] dout_prev_mem [N_CHAN];

    // -----------------------------------------------
    // Stage 1, fetch settings
    // -----------------------------------------------
    logic signed [pid_w_din-1:0] din_p1;
    pid_coef_t                   coef_p1;

    always_ff @(posedge clk_in) begin
        din_p1  <= sample_in.data;
        coef_p1 <= coef[idx(sample_in.chan)];
    end

    // -----------------------------------------------
    // Stage 2, error and k-coefficients
    // -----------------------------------------------
    logic signed [w_err-1:0] err_raw;
    logic signed [w_err-1:0] err_p2;
    logic signed [w_err-1:0] err_prev1_p2;
    logic signed [w_err-1:0] err_prev2_p2;
    logic signed [w_k-1:0]   k1_p2;
    logic signed [w_k-1:0]   k2_p2;
    logic signed [w_k-1:0]   k3_p2;

    assign err_raw = w_err'(coef_p1.setpoint) - w_err'(din_p1);

    always_ff @(posedge clk_in) begin
        // Complement gives -e-1
        err_p2 <= coef_p1.inv_error ? ~err_raw : err_raw;
        // Velocity form coefficients
        k1_p2 <= w_k'(coef_p1.p_coef) + w_k'(coef_p1.i_coef) + w_k'(coef_p1.d_coef);
        k2_p2 <= -w_k'(coef_p1.p_coef) - (w_k'(coef_p1.d_coef) <<< 1);
        k3_p2 <= w_k'(coef_p1.d_coef);
        // Previous two errors of this channel
        err_prev1_p2 <= err_prev1_mem[idx(chan_p[1])];
        err_prev2_p2 <= err_prev2_mem[idx(chan_p[1])];
    end

    // -----------------------------------------------
    // Stage 3, products and error writeback
    // -----------------------------------------------
    logic signed [w_prod-1:0] prod1_p3;
    logic signed [w_prod-1:0] prod2_p3;
    logic signed [w_prod-1:0] prod3_p3;

    always_ff @(posedge clk_in) begin
        prod1_p3 <= w_prod'(k1_p2) * w_prod'(err_p2);
        prod2_p3 <= w_prod'(k2_p2) * w_prod'(err_prev1_p2);
        prod3_p3 <= w_prod'(k3_p2) * w_prod'(err_prev2_p2);
    end

    // Shift error history, a clear overrides the write
    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            err_prev1_mem <= '{default: '0};
            err_prev2_mem <= '{default: '0};
        end else begin
            if (dv_p[2]) begin
                err_prev1_mem[idx(chan_p[2])] <= err_p2;
                err_prev2_mem[idx(chan_p[2])] <= err_prev1_p2;
            end
            for (int c = 0; c < N_CHAN; c++) begin
                if (clr[c]) begin
                    err_prev1_mem[c] <= '0;
                    err_prev2_mem[c] <= '0;
                end
            end
        end
    end

    // -----------------------------------------------
    // Stage 4, delta and previous output
    // -----------------------------------------------
    logic signed [w_delta-1:0] delta_p4;
    logic signed [W_DOUT-1:0]  dout_prev_p4;

    always_ff @(posedge clk_in) begin
        delta_p4 <= w_delta'(prod1_p3) + w_delta'(prod2_p3) + w_delta'(prod3_p3);
        // Written back two stages later
        dout_prev_p4 <= dout_prev_mem[idx(chan_p[3])];
    end

    // -----------------------------------------------
    // Stage 5, accumulate and saturate
    // -----------------------------------------------
    logic signed [w_sum-1:0]  sum_p5;
    logic signed [W_DOUT-1:0] dout_p5;

    assign sum_p5 = w_sum'(dout_prev_p4) + w_sum'(delta_p4);

    always_ff @(posedge clk_in) begin
        if (sum_p5 > w_sum'(max_dout)) begin
            dout_p5 <= max_dout;
        end else if (sum_p5 < w_sum'(min_dout)) begin
            dout_p5 <= min_dout;
        end else begin
            dout_p5 <= sum_p5[W_DOUT-1:0];
        end
    end

    // -----------------------------------------------
    // Stage 6, output writeback and register
    // -----------------------------------------------
    logic signed [W_DOUT-1:0] dout_p6;

    always_ff @(posedge clk_in) begin
        dout_p6 <= dout_p5;
    end

    // Saturated value becomes next previous output
    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            dout_prev_mem <= '{default: '0};
        end else begin
            if (dv_p[5]) begin
                dout_prev_mem[idx(chan_p[5])] <= dout_p5;
            end
            for (int c = 0; c < N_CHAN; c++) begin
                if (clr[c]) begin
                    dout_prev_mem[c] <= '0;
                end
            end
        end
    end

    assign dv_out   = dv_p[6];
    assign chan_out = chan_p[6];
    assign data_out = dout_p6;

    // -----------------------------------------------
    // Input rules
    // -----------------------------------------------
    // Output history is read in stage 4 and written in stage 6
    a_chan_spacing: assert property (@(posedge clk_in) disable iff (!rst_n)
        dv_in |-> !(($past(dv_in, 1) && $past(sample_in.chan, 1) == sample_in.chan) ||
                    ($past(dv_in, 2) && $past(sample_in.chan, 2) == sample_in.chan) ||
                    ($past(dv_in, 3) && $past(sample_in.chan, 3) == sample_in.chan)))
        else $error("channel %0d samples closer than 4 cycles", sample_in.chan);

    // Only configured channels may enter
    a_chan_range: assert property (@(posedge clk_in) disable iff (!rst_n)
        dv_in |-> (int'(sample_in.chan) < N_CHAN))
        else $error("sample on channel %0d beyond N_CHAN", sample_in.chan);

endmodule

// File: src/pid_param_regs.sv
`timescale 1ns/1ps

module pid_param_regs
    import pid_pkg::*;
#(
    parameter int N_CHAN = 8
) (
    input  logic                   clk_in,
    input  logic                   rst_n,
    // Register write bus
    input  logic                   wr_en,
    input  pid_wr_t                wr,
    // Per-channel settings
    output pid_coef_t [N_CHAN-1:0] coef,
    // One-cycle clear pulses
    output logic [N_CHAN-1:0]      clr
);

    // -----------------------------------------------
    // Write decode
    // -----------------------------------------------
    logic [N_CHAN-1:0]            wr_hit;
    logic                         clr_set;
    logic signed [pid_w_din-1:0]  wr_setpoint;
    logic signed [pid_w_coef-1:0] wr_coef;

    // Channel match, out-of-range channels hit nothing
    always_comb begin
        for (int c = 0; c < N_CHAN; c++) begin
            wr_hit[c] = wr_en && (int'(wr.chan) == c);
        end
    end

    // Field slices of the write data
    assign wr_setpoint = wr.data[pid_w_din-1:0];
    assign wr_coef     = wr.data[pid_w_coef-1:0];

    // Clear request with bit 0 set
    assign clr_set = (wr.addr == addr_clr_rqst) && wr.data[0];

    // -----------------------------------------------
    // Settings register file
    // -----------------------------------------------
    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            for (int c = 0; c < N_CHAN; c++) begin
                coef[c] <= pid_coef_reset;
            end
        end else begin
            for (int c = 0; c < N_CHAN; c++) begin
                if (wr_hit[c]) begin
                    case (wr.addr)
                        addr_setpoint:  coef[c].setpoint  <= wr_setpoint;
                        addr_p_coef:    coef[c].p_coef    <= wr_coef;
                        addr_i_coef:    coef[c].i_coef    <= wr_coef;
                        addr_d_coef:    coef[c].d_coef    <= wr_coef;
                        addr_inv_error: coef[c].inv_error <= wr.data[0];
                        // Clear request and unused addresses
                        default: ;
                    endcase
                end
            end
        end
    end

    // -----------------------------------------------
    // Clear pulses
    // -----------------------------------------------
    // High for the cycle after the write
    // Drops back to zero unless the request is repeated
    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            clr <= '0;
        end else begin
            for (int c = 0; c < N_CHAN; c++) begin
                clr[c] <= wr_hit[c] && clr_set;
            end
        end
    end

    // The filter relies on one-cycle flushes
    for (genvar g = 0; g < N_CHAN; g++) begin : g_clr_chk
        a_clr_pulse: assert property (@(posedge clk_in) disable iff (!rst_n)
            clr[g] |=> !clr[g])
            else $error("clr of channel %0d held for two cycles", g);
    end

endmodule

// File: src/pid_top.sv
`timescale 1ns/1ps

module pid_top
    import pid_pkg::*;
#(
    parameter int N_CHAN = 8,
    parameter int W_DOUT = 24
) (
    input  logic                     clk_in,
    input  logic                     rst_n,
    // Register write bus
    input  logic                     wr_en,
    input  pid_wr_t                  wr,
    // Sample stream
    input  logic                     dv_in,
    input  pid_sample_t              sample_in,
    // Controller output
    output logic                     dv_out,
    output logic [pid_w_chan-1:0]    chan_out,
    output logic signed [W_DOUT-1:0] data_out
);

    // Settings and clear pulses into the pipeline
    pid_coef_t [N_CHAN-1:0] coef;
    logic [N_CHAN-1:0]      clr;

    // Per-channel register file
    pid_param_regs #(
        .N_CHAN (N_CHAN)
    ) i_pid_param_regs (
        .clk_in (clk_in),
        .rst_n  (rst_n),
        .wr_en  (wr_en),
        .wr     (wr),
        .coef   (coef),
        .clr    (clr)
    );

    // Six-stage PID datapath
    pid_filter #(
        .N_CHAN (N_CHAN),
        .W_DOUT (W_DOUT)
    ) i_pid_filter (
        .clk_in    (clk_in),
        .rst_n     (rst_n),
        .dv_in     (dv_in),
        .sample_in (sample_in),
        .coef      (coef),
        .clr       (clr),
        .dv_out    (dv_out),
        .chan_out  (chan_out),
        .data_out  (data_out)
    );

endmodule
